/* program.hex */
// One instruction word per line, word 0 at byte address 0
// Bits 4..0 opcode, 7..5 Rx, 10..8 Ry, 15..8 imm8, 15..5 imm11
40D0 // 00 mvi r6,0x40
0530 // 02 mvi r1,5
0331 // 04 addi r1,3
0625 // 06 st r1,[r6]
FE50 // 08 mvi r2,-2
0222 // 0A sub r1,r2
02D1 // 0C addi r6,2
0625 // 0E st r1,[r6]
1236 // 10 mvhi r1,0x12
0160 // 12 mv r3,r1
0261 // 14 add r3,r2
0172 // 16 subi r3,1
02D1 // 18 addi r6,2
0665 // 1A st r3,[r6]
4090 // 1C mvi r4,0x40
04A4 // 1E ld r5,[r4]
01B1 // 20 addi r5,1
02D1 // 22 addi r6,2
06A5 // 24 st r5,[r6]
02D1 // 26 addi r6,2
04A4 // 28 ld r5,[r4]
06A5 // 2A st r5,[r6]
02D1 // 2C addi r6,2
08B3 // 2E cmpi r5,8
0029 // 30 jz +1
0645 // 32 st r2,[r6] wrong path
06A5 // 34 st r5,[r6]
02D1 // 36 addi r6,2
04A3 // 38 cmp r5,r4
0007 // 3A nop
0029 // 3C jz +1 not taken
002A // 3E jn +1
0645 // 40 st r2,[r6] wrong path
0685 // 42 st r4,[r6]
02D1 // 44 addi r6,2
03B3 // 46 cmpi r5,3
002A // 48 jn +1 not taken
06A5 // 4A st r5,[r6]
02D1 // 4C addi r6,2
05A3 // 4E cmp r5,r5
3370 // 50 mvi r3,0x33
0029 // 52 jz +1
0645 // 54 st r2,[r6] wrong path
0665 // 56 st r3,[r6]
02D1 // 58 addi r6,2
0028 // 5A j +1
0645 // 5C st r2,[r6] wrong path
00EC // 5E call +7
06E5 // 60 st r7,[r6]
FED0 // 62 mvi r6,-2
00D6 // 64 mvhi r6,0
ADB0 // 66 mvi r5,0xAD
DEB6 // 68 mvhi r5,0xDE
06A5 // 6A st r5,[r6]
FFE8 // 6C j -1
00ED // 6E jr r7
0645 // 70 st r2,[r6] squashed

/* all.f */
cpu_pkg.sv
regfile.sv
alu.sv
cpu_datapath.sv
cpu_control.sv
cpu_top.sv
tb_cpu_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_cpu_top -f all.f -o sim_cpu

./obj_dir/sim_cpu | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
  import cpu_pkg::*;
();

  localparam word_t RESET_PC = 16'h0000;
  localparam int NUM_TESTS = 11;
  localparam int TIMEOUT_CYCLES = 5000;
  // End marker is the last table entry
  localparam int END_IDX = NUM_TESTS - 1;

  logic  clk;
  logic  reset;
  word_t pc_addr;
  logic  pc_rd;
  word_t pc_rddata;
  word_t ldst_addr;
  word_t ldst_wrdata;
  logic  ldst_wr;
  logic  ldst_rd;
  word_t ldst_rddata;

  // Synchronous memories of 256 words each
  word_t imem [256];
  word_t dmem [256];
  logic  pc_pend;
  logic  ld_pend;
  word_t pc_addr_q;
  word_t ld_addr_q;

  // Expected store per address
  word_t exp_addr [NUM_TESTS];
  word_t exp_data [NUM_TESTS];
  string test_name [NUM_TESTS];
  int    write_cnt [NUM_TESTS];
  logic  data_ok [NUM_TESTS];
  logic  exp_hit;
  int    exp_idx;
  word_t exp_val;
  logic  done;

  // Failures counted by the assertions
  int err_reset;
  int err_addr;
  int err_data;
  int err_count;

  cpu_top #(
    .RESET_PC (RESET_PC)
  ) dut_i (
    .i_clk         (clk),
    .i_reset       (reset),
    .o_pc_addr     (pc_addr),
    .o_pc_rd       (pc_rd),
    .i_pc_rddata   (pc_rddata),
    .o_ldst_addr   (ldst_addr),
    .o_ldst_wrdata (ldst_wrdata),
    .o_ldst_wr     (ldst_wr),
    .o_ldst_rd     (ldst_rd),
    .i_ldst_rddata (ldst_rddata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Result address, expected value and name of each test
  task automatic load_expected();
    exp_addr[0]  = 16'h0040;
    exp_data[0]  = 16'd5 + 16'd3;
    test_name[0] = "mvi addi chain";
    exp_addr[1]  = 16'h0042;
    exp_data[1]  = 16'd8 - 16'hFFFE;
    test_name[1] = "sub with forwarded operand";
    exp_addr[2]  = 16'h0044;
    exp_data[2]  = 16'h120A + 16'hFFFE - 16'd1;
    test_name[2] = "mvhi mv add subi";
    exp_addr[3]  = 16'h0046;
    exp_data[3]  = 16'd8 + 16'd1;
    test_name[3] = "load then use";
    exp_addr[4]  = 16'h0048;
    exp_data[4]  = 16'd8;
    test_name[4] = "load then store";
    exp_addr[5]  = 16'h004A;
    exp_data[5]  = 16'd8;
    test_name[5] = "cmpi jz taken";
    exp_addr[6]  = 16'h004C;
    exp_data[6]  = 16'h0040;
    test_name[6] = "cmp nop jz jn";
    exp_addr[7]  = 16'h004E;
    exp_data[7]  = 16'd8;
    test_name[7] = "cmpi jn not taken";
    exp_addr[8]  = 16'h0050;
    exp_data[8]  = 16'h0033;
    test_name[8] = "cmp mvi jz taken";
    // Return address of the call at 0x5E
    exp_addr[9]  = 16'h0052;
    exp_data[9]  = 16'h005E + 16'd2;
    test_name[9] = "j call jr";
    exp_addr[10]  = 16'h00FE;
    exp_data[10]  = 16'hDEAD;
    test_name[10] = "end marker";
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      // nop opcode with the word index in the other fields
      imem[i] = {3'b000, i[7:0], 5'h07};
      dmem[i] = 16'hA500 ^ {i[7:0], i[7:0]};
    end
    $readmemh("program.hex", imem);
    load_expected();
    for (int i = 0; i < NUM_TESTS; i++) begin
      write_cnt[i] = 0;
      data_ok[i] = 1'b1;
    end
  end

  // Address and strobes taken at the rising edge
  always @(posedge clk) begin
    pc_pend   <= pc_rd;
    pc_addr_q <= pc_addr;
    ld_pend   <= ldst_rd;
    ld_addr_q <= ldst_addr;
    if (ldst_wr) begin
      dmem[ldst_addr[8:1]] <= ldst_wrdata;
    end
  end

  // Read data driven on the falling edge
  always @(negedge clk) begin
    if (pc_pend) begin
      pc_rddata <= imem[pc_addr_q[8:1]];
    end
    if (ld_pend) begin
      ldst_rddata <= dmem[ld_addr_q[8:1]];
    end
  end

  // Table lookup for the current store address
  always_comb begin
    exp_hit = 1'b0;
    exp_idx = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (exp_addr[i] == ldst_addr) begin
        exp_hit = 1'b1;
        exp_idx = i;
      end
    end
    exp_val = exp_data[exp_idx];
  end

  // One line per landed test store
  always @(posedge clk) begin
    if (!reset && ldst_wr && exp_hit) begin
      write_cnt[exp_idx] = write_cnt[exp_idx] + 1;
      if (ldst_wrdata != exp_val) begin
        data_ok[exp_idx] = 1'b0;
      end
      $display("Test %s: store to %h with %h (%s)", test_name[exp_idx], ldst_addr,
               ldst_wrdata, (ldst_wrdata == exp_val) ? "ok" : "mismatch");
      if (exp_idx == END_IDX) begin
        done = 1'b1;
      end
    end
  end

  // Strobes quiet in reset
  a_reset_quiet: assert property (@(posedge clk) reset |-> !(ldst_wr || ldst_rd || pc_rd))
    else begin
      $display("Memory strobe active during reset at %0t", $time);
      err_reset = err_reset + 1;
    end

  // Still quiet in the first cycle after reset
  a_first_quiet: assert property (@(posedge clk) $fell(reset) |-> !(ldst_wr || ldst_rd || pc_rd))
    else begin
      $display("Memory strobe active in first cycle after reset at %0t", $time);
      err_reset = err_reset + 1;
    end

  // Then the first fetch from the reset address
  a_first_fetch: assert property (@(posedge clk)
    $fell(reset) |=> (pc_rd && pc_addr == RESET_PC))
    else begin
      $display("Error at %0t: o_pc_addr expected %h actual %h (fetch %b)", $time,
               RESET_PC, $sampled(pc_addr), $sampled(pc_rd));
      err_reset = err_reset + 1;
    end

  // Wrong-path and squashed stores land outside the table or with a bad value
  a_store_addr: assert property (@(posedge clk) disable iff (reset) ldst_wr |-> exp_hit)
    else begin
      $display("Store to an address with no expected value (%h) at %0t",
               $sampled(ldst_addr), $time);
      err_addr = err_addr + 1;
    end

  a_store_data: assert property (@(posedge clk) disable iff (reset)
    (ldst_wr && exp_hit) |-> (ldst_wrdata == exp_val))
    else begin
      $display("Error at %0t: o_ldst_wrdata expected %h actual %h", $time,
               $sampled(exp_val), $sampled(ldst_wrdata));
      err_data = err_data + 1;
    end

  initial begin
    int cycles;
    int pass_cnt;
    int fail_cnt;
    reset       = 1'b1;
    pc_rddata   = NOP_WORD;
    ldst_rddata = '0;
    done        = 1'b0;
    err_reset   = 0;
    err_addr    = 0;
    err_data    = 0;
    err_count   = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (!done) begin
      $display("The program never finished within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end else begin
      // Let any late stray store show up
      repeat (20) @(posedge clk);
      pass_cnt = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
        a_once: assert (write_cnt[i] == 1)
          else begin
            $display("Address %h was written %0d times", exp_addr[i], write_cnt[i]);
            err_count = err_count + 1;
          end
        if (write_cnt[i] == 1 && data_ok[i]) begin
          pass_cnt = pass_cnt + 1;
        end
      end
      fail_cnt = NUM_TESTS - pass_cnt;
      $display("Tests passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt,
               err_reset + err_addr + err_data + err_count);
      if (fail_cnt == 0 && err_reset == 0 && err_addr == 0 && err_data == 0
          && err_count == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import cpu_pkg::*;
#(
  parameter word_t RESET_PC = 16'h0000
) (
  input  wire logic  i_clk,
  input  wire logic  i_reset,
  // Instruction port
  output word_t      o_pc_addr,
  output logic       o_pc_rd,
  input  wire word_t i_pc_rddata,
  // Data port
  output word_t      o_ldst_addr,
  output word_t      o_ldst_wrdata,
  output logic       o_ldst_wr,
  output logic       o_ldst_rd,
  input  wire word_t i_ldst_rddata
);

  ctrl_t   ctrl;
  status_t status;

  cpu_control m_control (
    .i_clk,
    .i_reset,
    .i_status  (status),
    .o_ctrl    (ctrl),
    .o_pc_rd,
    .o_ldst_rd,
    .o_ldst_wr
  );

  cpu_datapath #(
    .RESET_PC (RESET_PC)
  ) m_datapath (
    .i_clk,
    .i_reset,
    .i_ctrl        (ctrl),
    .o_status      (status),
    .o_pc_addr,
    .i_pc_rddata,
    .o_ldst_addr,
    .o_ldst_wrdata,
    .i_ldst_rddata
  );

endmodule

`default_nettype wire

/* cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control
  import cpu_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_reset,
  input  wire status_t i_status,
  output ctrl_t        o_ctrl,
  output logic         o_pc_rd,
  output logic         o_ldst_rd,
  output logic         o_ldst_wr
);

  typedef enum logic {
    ST_RESET,
    ST_RUN
  } state_e;

  state_e    r_state;
  // Fetched word is valid in decode
  logic      r_dc_valid;
  logic      run;
  opcode_e   op_dc;
  opcode_e   op_ex;
  opcode_e   op_wb;
  reg_addr_t rx_dc;
  reg_addr_t ry_dc;
  reg_addr_t rx_ex;
  reg_addr_t ry_ex;
  reg_addr_t dest_wb;
  logic      wb_writes;
  logic      fwd_ex_x;
  logic      fwd_ex_y;
  logic      ex_sets_flags;
  logic      flag_n;
  logic      flag_z;
  logic      ex_jr;
  logic      dc_taken;

  // ALU ops that update N and Z
  function automatic logic sets_flags(opcode_e op);
    return op inside {OP_ADD, OP_SUB, OP_CMP, OP_ADDI, OP_SUBI, OP_CMPI};
  endfunction

  // Ops with a register result (not cmp or cmpi)
  function automatic logic writes_reg(opcode_e op);
    return op inside {OP_MV, OP_ADD, OP_SUB, OP_LD, OP_CALL,
                      OP_MVI, OP_ADDI, OP_SUBI, OP_MVHI};
  endfunction

  // One idle cycle before the first fetch
  always_ff @(posedge i_clk, posedge i_reset) begin
    if (i_reset) begin
      r_state    <= ST_RESET;
      r_dc_valid <= 1'b0;
    end else begin
      r_state    <= ST_RUN;
      r_dc_valid <= run;
    end
  end

  assign run = (r_state == ST_RUN);

  // Per-stage fields
  assign op_dc = opcode_e'(i_status.ir_dc[4:0]);
  assign op_ex = opcode_e'(i_status.ir_ex[4:0]);
  assign op_wb = opcode_e'(i_status.ir_wr[4:0]);
  assign rx_dc = i_status.ir_dc[RX_LSB +: $bits(reg_addr_t)];
  assign ry_dc = i_status.ir_dc[RY_LSB +: $bits(reg_addr_t)];
  assign rx_ex = i_status.ir_ex[RX_LSB +: $bits(reg_addr_t)];
  assign ry_ex = i_status.ir_ex[RY_LSB +: $bits(reg_addr_t)];

  // call writes back to the link register
  assign dest_wb   = (op_wb == OP_CALL) ? LINK_REG
                                        : i_status.ir_wr[RX_LSB +: $bits(reg_addr_t)];
  assign wb_writes = writes_reg(op_wb);
  assign fwd_ex_x  = wb_writes && (dest_wb == rx_ex);
  assign fwd_ex_y  = wb_writes && (dest_wb == ry_ex);

  // Flags from the ALU when the instruction just ahead sets them
  assign ex_sets_flags = sets_flags(op_ex);
  assign flag_n = ex_sets_flags ? i_status.n_imm : i_status.n;
  assign flag_z = ex_sets_flags ? i_status.z_imm : i_status.z;

  assign ex_jr = (op_ex == OP_JR);

  // Decode-stage jumps lose to a jr in execute
  always_comb begin
    case (op_dc)
      OP_J,
      OP_CALL: dc_taken = 1'b1;
      OP_JZ:   dc_taken = flag_z;
      OP_JN:   dc_taken = flag_n;
      default: dc_taken = 1'b0;
    endcase
    dc_taken = dc_taken && r_dc_valid && !ex_jr;
  end

  always_comb begin
    o_ctrl = '0;
    o_ctrl.rf_write      = wb_writes;
    o_ctrl.dc_x_sel      = wb_writes && (dest_wb == rx_dc);
    o_ctrl.dc_y_sel      = wb_writes && (dest_wb == ry_dc);
    o_ctrl.alu_a_sel     = fwd_ex_x;
    o_ctrl.ldst_addr_sel = fwd_ex_y;
    o_ctrl.st_data_sel   = fwd_ex_x;
    // Immediate forms take imm8 on operand b
    if (op_ex[4]) begin
      o_ctrl.alu_b_sel = B_IMM;
    end else if (fwd_ex_y) begin
      o_ctrl.alu_b_sel = B_FWD;
    end else begin
      o_ctrl.alu_b_sel = B_REG;
    end
    o_ctrl.alu_op = (op_ex inside {OP_SUB, OP_CMP, OP_SUBI, OP_CMPI}) ? ALU_SUB : ALU_ADD;
    o_ctrl.ld_dc    = run;
    o_ctrl.ld_ex    = r_dc_valid;
    o_ctrl.ld_wb    = run;
    o_ctrl.ld_flags = ex_sets_flags;
    // Writeback source
    case (op_wb)
      OP_MVI:  o_ctrl.wb_sel = WB_IMM8;
      OP_MVHI: o_ctrl.wb_sel = WB_MVHI;
      OP_CALL: o_ctrl.wb_sel = WB_RET;
      OP_LD:   o_ctrl.wb_sel = WB_LOAD;
      OP_MV:   o_ctrl.wb_sel = WB_MOVE;
      default: o_ctrl.wb_sel = WB_ALU;
    endcase
    o_ctrl.link_sel = (op_wb == OP_CALL);
    // jr wins over any jump sitting in decode
    if (ex_jr) begin
      o_ctrl.pc_sel      = PC_REG;
      o_ctrl.pc_addr_sel = PC_REG;
      o_ctrl.squash      = 1'b1;
    end else if (dc_taken) begin
      o_ctrl.pc_sel      = PC_JMP;
      o_ctrl.pc_addr_sel = PC_JMP;
    end else begin
      o_ctrl.pc_sel      = PC_SEQ;
      o_ctrl.pc_addr_sel = PC_SEQ;
    end
  end

  // Memory strobes
  assign o_pc_rd   = run;
  assign o_ldst_rd = (op_ex == OP_LD);
  assign o_ldst_wr = (op_ex == OP_ST);

  a_ldst_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_ldst_rd && o_ldst_wr));

  // Slot behind a jr reaches execute as a nop
  a_squash_jr: assert property (@(posedge i_clk) disable iff (i_reset)
    o_ctrl.squash |=> (i_status.ir_ex == NOP_WORD));

endmodule

`default_nettype wire

/* cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath
  import cpu_pkg::*;
#(
  parameter word_t RESET_PC = 16'h0000
) (
  input  wire logic    i_clk,
  input  wire logic    i_reset,
  input  wire ctrl_t   i_ctrl,
  output status_t      o_status,
  output word_t        o_pc_addr,
  input  wire word_t   i_pc_rddata,
  output word_t        o_ldst_addr,
  output word_t        o_ldst_wrdata,
  input  wire word_t   i_ldst_rddata
);

  // Stage registers
  word_t r_pc;
  word_t r_pc_dc;
  word_t r_pc_ex;
  word_t r_pc_wr;
  word_t r_ir_ex;
  word_t r_ir_wr;
  word_t r_rf_datax;
  word_t r_rf_datay;
  word_t r_alu_r;
  logic  r_alu_n;
  logic  r_alu_z;
  word_t r_datax_wr;
  word_t r_datay_wr;

  // Combinational paths
  word_t     ir_dc;
  word_t     imm11_dc;
  word_t     jmp_pc;
  word_t     pc_addr;
  word_t     pc_in;
  reg_addr_t rf_addrw;
  word_t     rf_data_in;
  word_t     rf_datax_out;
  word_t     rf_datay_out;
  word_t     dc_x;
  word_t     dc_y;
  word_t     ir_ex_in;
  word_t     imm8_ex;
  word_t     alu_op_a;
  word_t     alu_op_b;
  word_t     ex_y;
  word_t     alu_out;
  logic      alu_n;
  logic      alu_z;
  word_t     ret_addr;

  regfile m_regfile (
    .i_clk,
    .i_reset,
    .i_write     (i_ctrl.rf_write),
    .i_addrw     (rf_addrw),
    .i_addrx     (ir_dc[RX_LSB +: $bits(reg_addr_t)]),
    .i_addry     (ir_dc[RY_LSB +: $bits(reg_addr_t)]),
    .i_data_in   (rf_data_in),
    .o_datax_out (rf_datax_out),
    .o_datay_out (rf_datay_out)
  );

  alu m_alu (
    .i_op_sel  (i_ctrl.alu_op),
    .i_op_a    (alu_op_a),
    .i_op_b    (alu_op_b),
    .o_alu_out (alu_out),
    .o_n       (alu_n),
    .o_z       (alu_z)
  );

  always_ff @(posedge i_clk, posedge i_reset) begin
    if (i_reset) begin
      r_pc       <= RESET_PC;
      r_pc_dc    <= '0;
      r_pc_ex    <= '0;
      r_pc_wr    <= '0;
      r_ir_ex    <= '0;
      r_ir_wr    <= '0;
      r_rf_datax <= '0;
      r_rf_datay <= '0;
      r_alu_r    <= '0;
      r_alu_n    <= 1'b0;
      r_alu_z    <= 1'b0;
      r_datax_wr <= '0;
      r_datay_wr <= '0;
    end else begin
      // Prefetch and fetch
      if (i_ctrl.ld_dc) begin
        r_pc    <= pc_in;
        r_pc_dc <= pc_addr;
      end
      // Decode into execute
      if (i_ctrl.ld_ex) begin
        r_ir_ex    <= ir_ex_in;
        r_pc_ex    <= r_pc_dc;
        r_rf_datax <= dc_x;
        r_rf_datay <= dc_y;
      end
      if (i_ctrl.ld_flags) begin
        r_alu_n <= alu_n;
        r_alu_z <= alu_z;
      end
      // Execute into writeback
      if (i_ctrl.ld_wb) begin
        r_ir_wr    <= r_ir_ex;
        r_pc_wr    <= r_pc_ex;
        r_alu_r    <= alu_out;
        r_datax_wr <= alu_op_a;
        r_datay_wr <= ex_y;
      end
    end
  end

  // Decode sees the fetched word directly
  assign ir_dc    = i_pc_rddata;
  assign imm11_dc = {{5{ir_dc[15]}}, ir_dc[15:IMM11_LSB]};
  // Branch address + 2 + 2 * imm11
  assign jmp_pc   = r_pc_dc + INSTR_SIZE + (imm11_dc << 1);

  // Fetch address, jr target comes off the forwarded operand a
  always_comb begin
    case (i_ctrl.pc_addr_sel)
      PC_JMP:  pc_addr = jmp_pc;
      PC_REG:  pc_addr = alu_op_a;
      default: pc_addr = r_pc;
    endcase
  end

  // Next sequential PC after whatever goes out this cycle
  always_comb begin
    case (i_ctrl.pc_sel)
      PC_JMP:  pc_in = jmp_pc + INSTR_SIZE;
      PC_REG:  pc_in = alu_op_a + INSTR_SIZE;
      default: pc_in = r_pc + INSTR_SIZE;
    endcase
  end

  // Decode operands with writeback forwarding
  assign dc_x = i_ctrl.dc_x_sel ? rf_data_in : rf_datax_out;
  assign dc_y = i_ctrl.dc_y_sel ? rf_data_in : rf_datay_out;
  // Instruction behind a jr becomes a nop
  assign ir_ex_in = i_ctrl.squash ? NOP_WORD : ir_dc;

  // Execute operands
  assign imm8_ex  = {{8{r_ir_ex[15]}}, r_ir_ex[15:IMM8_LSB]};
  assign alu_op_a = i_ctrl.alu_a_sel ? rf_data_in : r_rf_datax;
  assign ex_y     = i_ctrl.ldst_addr_sel ? rf_data_in : r_rf_datay;

  always_comb begin
    case (i_ctrl.alu_b_sel)
      B_FWD:   alu_op_b = rf_data_in;
      B_IMM:   alu_op_b = imm8_ex;
      default: alu_op_b = r_rf_datay;
    endcase
  end

  // Data port, address from Ry and data from Rx
  assign o_ldst_addr   = ex_y;
  assign o_ldst_wrdata = i_ctrl.st_data_sel ? rf_data_in : r_rf_datax;

  // Writeback
  assign ret_addr = r_pc_wr + INSTR_SIZE;
  assign rf_addrw = i_ctrl.link_sel ? LINK_REG : r_ir_wr[RX_LSB +: $bits(reg_addr_t)];

  always_comb begin
    case (i_ctrl.wb_sel)
      WB_IMM8: rf_data_in = {{8{r_ir_wr[15]}}, r_ir_wr[15:IMM8_LSB]};
      // imm8 into the upper byte, low byte of Rx kept
      WB_MVHI: rf_data_in = {r_ir_wr[15:IMM8_LSB], r_datax_wr[7:0]};
      WB_RET:  rf_data_in = ret_addr;
      WB_LOAD: rf_data_in = i_ldst_rddata;
      WB_MOVE: rf_data_in = r_datay_wr;
      default: rf_data_in = r_alu_r;
    endcase
  end

  assign o_pc_addr = pc_addr;

  always_comb begin
    o_status.ir_dc = ir_dc;
    o_status.ir_ex = r_ir_ex;
    o_status.ir_wr = r_ir_wr;
    o_status.n     = r_alu_n;
    o_status.z     = r_alu_z;
    o_status.n_imm = alu_n;
    o_status.z_imm = alu_z;
  end

  // Jump targets and jr registers must stay halfword aligned
  a_pc_even: assert property (@(posedge i_clk) disable iff (i_reset) !o_pc_addr[0]);

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
  import cpu_pkg::*;
(
  input  wire alu_op_e i_op_sel,
  input  wire word_t   i_op_a,
  input  wire word_t   i_op_b,
  output word_t        o_alu_out,
  output logic         o_n,
  output logic         o_z
);

  // cmp shares the subtract path
  always_comb begin
    if (i_op_sel == ALU_SUB) begin
      o_alu_out = i_op_a - i_op_b;
    end else begin
      o_alu_out = i_op_a + i_op_b;
    end
  end

  // Sign and zero of the result
  assign o_n = o_alu_out[$bits(word_t)-1];
  assign o_z = (o_alu_out == '0);

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
  import cpu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  input  wire logic      i_write,
  input  wire reg_addr_t i_addrw,
  input  wire reg_addr_t i_addrx,
  input  wire reg_addr_t i_addry,
  input  wire word_t     i_data_in,
  output word_t          o_datax_out,
  output word_t          o_datay_out
);

  word_t r_regs [NUM_REGS];

  // Single write port, written at the clock edge
  always_ff @(posedge i_clk, posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_write) begin
      r_regs[i_addrw] <= i_data_in;
    end
  end

  // Reads see the old value during a write
  // Same-cycle hazards are covered by forwarding in the datapath
  assign o_datax_out = r_regs[i_addrx];
  assign o_datay_out = r_regs[i_addry];

  // Writeback destination must be resolved
  a_addrw_known: assert property (@(posedge i_clk) disable iff (i_reset)
    i_write |-> !$isunknown(i_addrw));

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Data, instruction and address word
  typedef logic [15:0] word_t;
  // Register number
  typedef logic [2:0] reg_addr_t;
  // Writeback source select
  typedef logic [2:0] wb_sel_t;
  // PC and fetch address select
  typedef logic [1:0] pc_sel_t;
  // ALU operand b select
  typedef logic [1:0] b_sel_t;

  localparam int NUM_REGS = 8;
  // call writes its return address here
  localparam reg_addr_t LINK_REG = 3'd7;
  localparam word_t NOP_WORD = 16'h0007;
  localparam word_t INSTR_SIZE = 16'd2;

  // Instruction field positions
  localparam int RX_LSB = 5;
  localparam int RY_LSB = 8;
  localparam int IMM8_LSB = 8;
  localparam int IMM11_LSB = 5;

  // Bit 4 marks the immediate form
  typedef enum logic [4:0] {
    OP_MV   = 5'd0,  OP_ADD  = 5'd1,  OP_SUB  = 5'd2,  OP_CMP = 5'd3,
    OP_LD   = 5'd4,  OP_ST   = 5'd5,  OP_NOP  = 5'd7,
    OP_J    = 5'd8,  OP_JZ   = 5'd9,  OP_JN   = 5'd10, OP_CALL = 5'd12,
    OP_JR   = 5'd13,
    OP_MVI  = 5'd16, OP_ADDI = 5'd17, OP_SUBI = 5'd18, OP_CMPI = 5'd19,
    OP_MVHI = 5'd22
  } opcode_e;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  // Writeback sources
  localparam wb_sel_t WB_IMM8 = 3'd0;
  localparam wb_sel_t WB_MVHI = 3'd1;
  localparam wb_sel_t WB_ALU  = 3'd2;
  localparam wb_sel_t WB_RET  = 3'd3;
  localparam wb_sel_t WB_LOAD = 3'd4;
  localparam wb_sel_t WB_MOVE = 3'd5;

  // Next PC and fetch address sources
  localparam pc_sel_t PC_SEQ = 2'd0;
  localparam pc_sel_t PC_JMP = 2'd1;
  localparam pc_sel_t PC_REG = 2'd2;

  // ALU operand b sources
  localparam b_sel_t B_FWD = 2'd0;
  localparam b_sel_t B_IMM = 2'd1;
  localparam b_sel_t B_REG = 2'd2;

  typedef struct packed {
    logic    rf_write;
    // Forwarding from writeback
    logic    dc_x_sel;
    logic    dc_y_sel;
    logic    alu_a_sel;
    b_sel_t  alu_b_sel;
    logic    ldst_addr_sel;
    logic    st_data_sel;
    // Stage register loads
    logic    ld_dc;
    logic    ld_ex;
    logic    ld_wb;
    logic    ld_flags;
    alu_op_e alu_op;
    wb_sel_t wb_sel;
    logic    link_sel;
    pc_sel_t pc_sel;
    pc_sel_t pc_addr_sel;
    logic    squash;
  } ctrl_t;

  typedef struct packed {
    word_t ir_dc;
    word_t ir_ex;
    word_t ir_wr;
    logic  n;
    logic  z;
    // Straight from the ALU, not yet registered
    logic  n_imm;
    logic  z_imm;
  } status_t;

endpackage

`default_nettype wire
